/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_fb_backend
FILELIST  = fb_backend_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* buffer_sequencer.sv */
//**************************************************************************
// Frame command sequencer: launches clears, signals the display swap and
// reports completion once both stores and the display are done
//**************************************************************************
`timescale 1ns/10ps

module buffer_sequencer (
    input  logic                clk,
    input  logic                rst,

    input  logic                cmd_valid,
    input  raster_pkg::fb_cmd_e cmd,

    input  logic                color_idle,
    input  logic                depth_idle,
    input  logic                fb_swapped,

    output logic                clear_start,
    output logic                swap_fb,
    output logic                busy,
    output logic                cmd_done
);
    import raster_pkg::*;

    seq_state_e state;
    logic       swap_pending;

    logic       accept;
    logic       is_memset;
    logic       is_swap;
    logic       release_ok;

    assign accept     = cmd_valid && !busy && (cmd != CMD_NONE);
    assign is_memset  = (cmd == CMD_MEMSET) || (cmd == CMD_MEMSET_SWAP);
    assign is_swap    = (cmd == CMD_SWAP) || (cmd == CMD_MEMSET_SWAP);
    assign release_ok = color_idle && depth_idle && (!swap_pending || fb_swapped);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= SEQ_IDLE;
            busy         <= 1'b0;
            clear_start  <= 1'b0;
            swap_fb      <= 1'b0;
            cmd_done     <= 1'b0;
            swap_pending <= 1'b0;
        end
        else
        begin
            clear_start <= 1'b0;
            swap_fb     <= 1'b0;
            cmd_done    <= 1'b0;

            case (state)
                SEQ_IDLE:
                begin
                    if (accept)
                    begin
                        state        <= SEQ_LAUNCH;
                        busy         <= 1'b1;
                        clear_start  <= is_memset;
                        swap_fb      <= is_swap;
                        swap_pending <= is_swap;
                    end
                end

                // Stores take the clear strobe at the end of this cycle,
                // their idle level is only valid from the next one
                SEQ_LAUNCH:
                begin
                    state <= SEQ_WAIT;
                end

                SEQ_WAIT:
                begin
                    if (release_ok)
                    begin
                        state        <= SEQ_IDLE;
                        busy         <= 1'b0;
                        cmd_done     <= 1'b1;
                        swap_pending <= 1'b0;
                    end
                end

                default:
                begin
                    state <= SEQ_IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* fb_backend_top.f */
+incdir+.
raster_pkg.sv
framebuffer_tile.sv
buffer_sequencer.sv
fb_backend_top.sv
tb_fb_backend.sv

/* fb_backend_top.sv */
//**************************************************************************
// Framebuffer back end: colour and depth tile stores with the frame
// command sequencer, colour kept as RGB565 inside the colour store
//**************************************************************************
`timescale 1ns/10ps

module fb_backend_top (
    input  logic                                clk,
    input  logic                                rst,

    input  raster_pkg::fb_config_t              cfg,

    input  logic                                cmd_valid,
    input  raster_pkg::fb_cmd_e                 cmd,

    input  logic                                wr_valid,
    input  raster_pkg::screen_pos_t             wr_pos,
    input  raster_pkg::rgba8888_t               wr_color,
    input  logic [raster_pkg::depth_width-1:0]  wr_depth,

    input  logic                                rd_valid,
    input  raster_pkg::screen_pos_t             rd_pos,

    input  logic                                fb_swapped,

    output logic                                color_rd_valid,
    output raster_pkg::rgba8888_t               color_rd_data,
    output logic                                depth_rd_valid,
    output logic [raster_pkg::depth_width-1:0]  depth_rd_data,

    output logic                                busy,
    output logic                                swap_fb,
    output logic                                cmd_done
);
    import raster_pkg::*;

    logic                    clear_start;
    logic                    color_idle;
    logic                    depth_idle;

    logic                    frag_wr_valid;
    logic                    frag_rd_valid;

    rgb565_t                 color_wr_data;
    rgb565_t                 color_clear_value;
    logic [rgb565_width-1:0] color_rd_raw;

    // No fragment traffic while a command is in flight
    assign frag_wr_valid = wr_valid && !busy;
    assign frag_rd_valid = rd_valid && !busy;

    assign color_wr_data     = to_rgb565(wr_color);
    assign color_clear_value = to_rgb565(cfg.clear_color);
    assign color_rd_data     = from_rgb565(color_rd_raw);

    buffer_sequencer seq (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .color_idle  (color_idle),
        .depth_idle  (depth_idle),
        .fb_swapped  (fb_swapped),
        .clear_start (clear_start),
        .swap_fb     (swap_fb),
        .busy        (busy),
        .cmd_done    (cmd_done)
    );

    framebuffer_tile #(
        .pixel_width (rgb565_width)
    ) color_tile (
        .clk           (clk),
        .rst           (rst),
        .scissor       (cfg.scissor),
        .clear_value   (color_clear_value),
        .write_enable  (cfg.color_write_enable),
        .clear_start   (clear_start),
        .wr_valid      (frag_wr_valid),
        .wr_pos        (wr_pos),
        .wr_data       (color_wr_data),
        .rd_valid      (frag_rd_valid),
        .rd_pos        (rd_pos),
        .rd_data_valid (color_rd_valid),
        .rd_data       (color_rd_raw),
        .idle          (color_idle)
    );

    framebuffer_tile #(
        .pixel_width (depth_width)
    ) depth_tile (
        .clk           (clk),
        .rst           (rst),
        .scissor       (cfg.scissor),
        .clear_value   (cfg.clear_depth),
        .write_enable  (cfg.depth_write_enable),
        .clear_start   (clear_start),
        .wr_valid      (frag_wr_valid),
        .wr_pos        (wr_pos),
        .wr_data       (wr_depth),
        .rd_valid      (frag_rd_valid),
        .rd_pos        (rd_pos),
        .rd_data_valid (depth_rd_valid),
        .rd_data       (depth_rd_data),
        .idle          (depth_idle)
    );

endmodule

/* framebuffer_tile.sv */
//**************************************************************************
// Framebuffer tile store with fragment read/write port, scissor test,
// channel write mask and a clear walker that sweeps the whole tile
//**************************************************************************
`timescale 1ns/10ps

module framebuffer_tile #(
    parameter int pixel_width = 16
)
(
    input  logic                        clk,
    input  logic                        rst,

    input  raster_pkg::scissor_t        scissor,
    input  logic [pixel_width-1:0]      clear_value,
    input  logic                        write_enable,
    input  logic                        clear_start,

    input  logic                        wr_valid,
    input  raster_pkg::screen_pos_t     wr_pos,
    input  logic [pixel_width-1:0]      wr_data,

    input  logic                        rd_valid,
    input  raster_pkg::screen_pos_t     rd_pos,
    output logic                        rd_data_valid,
    output logic [pixel_width-1:0]      rd_data,

    output logic                        idle
);
    import raster_pkg::*;

    function automatic logic in_scissor(input scissor_t sc, input screen_pos_t pos);
        logic inside_x;
        logic inside_y;
        inside_x = (pos.x >= sc.start_pos.x) && (pos.x < sc.end_pos.x);
        inside_y = (pos.y >= sc.start_pos.y) && (pos.y < sc.end_pos.y);
        return !sc.enable || (inside_x && inside_y);
    endfunction

    // Row major, y in the upper bits
    function automatic logic [index_width-1:0] pos_index(input screen_pos_t pos);
        return {pos.y, pos.x};
    endfunction

    logic [pixel_width-1:0] mem [pixel_count];

    logic                   running;
    logic [index_width-1:0] walk_idx;
    screen_pos_t            walk_pos;

    logic                   mem_we;
    logic [index_width-1:0] mem_addr;
    logic [pixel_width-1:0] mem_wdata;

    assign walk_pos.x = walk_idx[x_width-1:0];
    assign walk_pos.y = walk_idx[index_width-1:x_width];

    // Single write port shared by the walker and fragment writes
    always_comb
    begin
        if (running)
        begin
            mem_addr  = walk_idx;
            mem_wdata = clear_value;
            mem_we    = write_enable && in_scissor(scissor, walk_pos);
        end
        else
        begin
            mem_addr  = pos_index(wr_pos);
            mem_wdata = wr_data;
            mem_we    = wr_valid && write_enable && in_scissor(scissor, wr_pos);
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_we)
        begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            rd_data <= mem[pos_index(rd_pos)];
        end
    end

    // Reads are dropped while the clear runs
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_data_valid <= 1'b0;
        end
        else
        begin
            rd_data_valid <= rd_valid && !running;
        end
    end

    // Clear walker, one pixel per cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running  <= 1'b0;
            walk_idx <= '0;
        end
        else if (running)
        begin
            walk_idx <= walk_idx + 1'b1;
            if (walk_idx == index_width'(pixel_count - 1))
            begin
                running <= 1'b0;
            end
        end
        else if (clear_start)
        begin
            running  <= 1'b1;
            walk_idx <= '0;
        end
    end

    assign idle = !running;

endmodule

/* raster_pkg.sv */
//**************************************************************************
// Shared tile sizes, pixel and config types, frame command encodings and
// the RGBA8888 to RGB565 colour conversion used by the framebuffer back end
//**************************************************************************
package raster_pkg;

    // Tile geometry
    localparam int screen_w = 16;
    localparam int screen_h = 8;
    localparam int x_width = $clog2(screen_w);
    localparam int y_width = $clog2(screen_h);
    localparam int pixel_count = screen_w * screen_h;
    localparam int index_width = x_width + y_width;

    // Pixel formats
    localparam int depth_width = 16;
    localparam int rgb565_width = 16;
    localparam logic [7:0] default_alpha = 8'h00;

    typedef struct packed {
        logic [x_width-1:0] x;
        logic [y_width-1:0] y;
    } screen_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] a;
    } rgba8888_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // End position is exclusive
    typedef struct packed {
        logic        enable;
        screen_pos_t start_pos;
        screen_pos_t end_pos;
    } scissor_t;

    typedef struct packed {
        scissor_t               scissor;
        rgba8888_t              clear_color;
        logic [depth_width-1:0] clear_depth;
        logic                   color_write_enable;
        logic                   depth_write_enable;
    } fb_config_t;

    typedef enum logic [1:0] {
        CMD_NONE        = 2'd0,
        CMD_MEMSET      = 2'd1,
        CMD_SWAP        = 2'd2,
        CMD_MEMSET_SWAP = 2'd3
    } fb_cmd_e;

    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_LAUNCH = 2'd1,
        SEQ_WAIT   = 2'd2
    } seq_state_e;

    // Drops the low bits of each channel, alpha is not stored
    function automatic rgb565_t to_rgb565(input rgba8888_t color);
        rgb565_t result;
        result.r = color.r[7:3];
        result.g = color.g[7:2];
        result.b = color.b[7:3];
        return result;
    endfunction

    // Low bits come back as zero
    function automatic rgba8888_t from_rgb565(input rgb565_t color);
        rgba8888_t result;
        result.r = {color.r, 3'b000};
        result.g = {color.g, 2'b00};
        result.b = {color.b, 3'b000};
        result.a = default_alpha;
        return result;
    endfunction

endpackage

/* tb_fb_model.svh */
//**************************************************************************
// Reference model of the colour and depth stores for the back end testbench
//**************************************************************************

rgba8888_t              model_color [pixel_count];
logic [depth_width-1:0] model_depth [pixel_count];

function automatic int pixel_index(input screen_pos_t p);
    return int'(p.y) * screen_w + int'(p.x);
endfunction

// Exclusive end, disabled scissor passes every pixel
function automatic logic inside_scissor(input scissor_t s, input screen_pos_t p);
    logic in_x;
    logic in_y;
    in_x = (p.x >= s.start_pos.x) && (p.x < s.end_pos.x);
    in_y = (p.y >= s.start_pos.y) && (p.y < s.end_pos.y);
    return !s.enable || (in_x && in_y);
endfunction

// What a colour looks like after a trip through RGB565
function automatic rgba8888_t stored_color(input rgba8888_t c);
    rgba8888_t q;
    q.r = c.r & 8'hf8;
    q.g = c.g & 8'hfc;
    q.b = c.b & 8'hf8;
    q.a = 8'h00;
    return q;
endfunction

task automatic model_write(input fb_config_t c, input screen_pos_t p,
                           input rgba8888_t color, input logic [depth_width-1:0] depth);
    if (inside_scissor(c.scissor, p))
    begin
        if (c.color_write_enable)
            model_color[pixel_index(p)] = stored_color(color);
        if (c.depth_write_enable)
            model_depth[pixel_index(p)] = depth;
    end
endtask

task automatic model_clear(input fb_config_t c);
    screen_pos_t p;
    for (int i = 0; i < pixel_count; i++)
    begin
        p.x = x_width'(i % screen_w);
        p.y = y_width'(i / screen_w);
        model_write(c, p, c.clear_color, c.clear_depth);
    end
endtask

/* tb_fb_backend.sv */
//**************************************************************************
// Testbench for the framebuffer back end with random traffic and a model
//**************************************************************************
`timescale 1ns/10ps

module tb_fb_backend;
    import raster_pkg::*;

    localparam int clk_period = 40;
    localparam int rounds = 6;
    localparam int frag_ops = 40;
    localparam int max_delay = 20;
    localparam int num_cmds = rounds + 1;
    localparam int num_frag = num_cmds * (frag_ops + pixel_count);
    localparam int watchdog_cycles = 2 * (num_cmds * (pixel_count + max_delay) + num_frag) + 200;

    logic                   clk;
    logic                   rst;
    fb_config_t             cfg;
    logic                   cmd_valid;
    fb_cmd_e                cmd;
    logic                   wr_valid;
    screen_pos_t            wr_pos;
    rgba8888_t              wr_color;
    logic [depth_width-1:0] wr_depth;
    logic                   rd_valid;
    screen_pos_t            rd_pos;
    logic                   fb_swapped;
    logic                   color_rd_valid;
    rgba8888_t              color_rd_data;
    logic                   depth_rd_valid;
    logic [depth_width-1:0] depth_rd_data;
    logic                   busy;
    logic                   swap_fb;
    logic                   cmd_done;

    integer                 seed;
    logic [31:0]            rnd;
    int                     errors;
    int                     checks;

    // Expected DUT state as seen on the falling edge
    logic                   model_busy;
    logic                   rd_pend;
    logic                   swap_pend;
    logic                   cur_memset;
    logic                   cur_swap;
    logic                   swapped_seen;
    int                     busy_cycles;
    rgba8888_t              exp_color;
    logic [depth_width-1:0] exp_depth;

    `include "tb_fb_model.svh"

    fb_backend_top i_fb_backend_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic compare_bit(input string what, input logic got, input logic expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("[FAIL] %0t %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("[FAIL] %0t %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    always @(negedge clk)
    begin
        if (rst)
        begin
            model_busy = 1'b0;
            rd_pend = 1'b0;
            swap_pend = 1'b0;
            swapped_seen = 1'b0;
        end
        else
        begin
            compare_bit("color_rd_valid", color_rd_valid, rd_pend);
            compare_bit("depth_rd_valid", depth_rd_valid, rd_pend);
            if (rd_pend)
            begin
                compare_word("color_rd_data", color_rd_data, exp_color);
                compare_word("depth_rd_data", 32'(depth_rd_data), 32'(exp_depth));
            end
            compare_bit("swap_fb", swap_fb, swap_pend);
            if (cmd_done)
            begin
                assert (model_busy) else report_error("cmd_done pulsed with no command running");
                assert (!cur_swap || swapped_seen)
                    else report_error("cmd_done came before fb_swapped was raised");
                assert (!cur_memset || busy_cycles >= pixel_count)
                    else report_error("cmd_done came before the clear could finish");
                model_busy = 1'b0;
            end
            compare_bit("busy", busy, model_busy);
            // Inputs of this cycle take effect at the next rising edge
            rd_pend = rd_valid && !model_busy;
            if (rd_pend)
            begin
                exp_color = model_color[pixel_index(rd_pos)];
                exp_depth = model_depth[pixel_index(rd_pos)];
            end
            if (wr_valid && !model_busy)
                model_write(cfg, wr_pos, wr_color, wr_depth);
            swap_pend = 1'b0;
            if (model_busy)
            begin
                busy_cycles++;
                if (fb_swapped)
                    swapped_seen = 1'b1;
            end
            else if (cmd_valid && cmd != CMD_NONE)
            begin
                model_busy = 1'b1;
                cur_memset = (cmd == CMD_MEMSET) || (cmd == CMD_MEMSET_SWAP);
                cur_swap = (cmd == CMD_SWAP) || (cmd == CMD_MEMSET_SWAP);
                swap_pend = cur_swap;
                swapped_seen = 1'b0;
                busy_cycles = 0;
                if (cur_memset)
                    model_clear(cfg);
            end
        end
    end

    // Scissor rectangle is never empty and never covers the last column or row
    task automatic pick_config(input logic full);
        fb_config_t c;
        rnd = $random(seed);
        c.clear_color = rnd;
        rnd = $random(seed);
        c.clear_depth = rnd[15:0];
        c.scissor.enable = !full;
        c.scissor.start_pos.x = {1'b0, rnd[18:16]};
        c.scissor.end_pos.x = c.scissor.start_pos.x + {1'b0, rnd[21:19]} + 4'd1;
        c.scissor.start_pos.y = {1'b0, rnd[23:22]};
        c.scissor.end_pos.y = c.scissor.start_pos.y + {1'b0, rnd[25:24]} + 3'd1;
        rnd = $random(seed);
        c.color_write_enable = full || (rnd[1:0] != 2'b00);
        c.depth_write_enable = full || (rnd[3:2] != 2'b00);
        @(posedge clk);
        cfg <= c;
    endtask

    // Random writes and reads plus stray commands while one is already running
    task automatic random_traffic(input int cycles, input logic with_cmds);
        repeat (cycles)
        begin
            @(posedge clk);
            rnd = $random(seed);
            wr_valid <= rnd[0];
            rd_valid <= rnd[1];
            wr_pos <= rnd[8:2];
            rd_pos <= rnd[15:9];
            cmd_valid <= with_cmds && rnd[16];
            cmd <= fb_cmd_e'(rnd[18:17]);
            wr_depth <= rnd[31:16];
            rnd = $random(seed);
            wr_color <= rnd;
        end
        @(posedge clk);
        wr_valid <= 1'b0;
        rd_valid <= 1'b0;
        cmd_valid <= 1'b0;
    endtask

    task automatic run_command(input fb_cmd_e c);
        int delay;
        rnd = $random(seed);
        delay = 1 + int'(rnd[4:0]) % max_delay;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd <= c;
        random_traffic(delay, 1'b1);
        if (c == CMD_SWAP || c == CMD_MEMSET_SWAP)
            fb_swapped <= 1'b1;
        @(negedge clk);
        while (!cmd_done)
            @(negedge clk);
        @(posedge clk);
        fb_swapped <= 1'b0;
    endtask

    task automatic read_all;
        for (int i = 0; i < pixel_count; i++)
        begin
            @(posedge clk);
            rd_valid <= 1'b1;
            rd_pos.x <= x_width'(i % screen_w);
            rd_pos.y <= y_width'(i / screen_w);
        end
        @(posedge clk);
        rd_valid <= 1'b0;
    endtask

    initial
    begin
        seed = 91;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        cfg = '0;
        cmd_valid = 1'b0;
        cmd = CMD_NONE;
        wr_valid = 1'b0;
        wr_pos = '0;
        wr_color = '0;
        wr_depth = '0;
        rd_valid = 1'b0;
        rd_pos = '0;
        fb_swapped = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        pick_config(1'b1);
        run_command(CMD_MEMSET);
        read_all();
        for (int r = 0; r < rounds; r++)
        begin
            pick_config(1'b0);
            random_traffic(frag_ops, 1'b0);
            run_command(fb_cmd_e'(2'(r % 3 + 1)));
            read_all();
        end
        repeat (3) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule
